/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_cam_qspi_top
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '** PASS **' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* src.f */
src/fb_pkg.sv
src/cam_byte_packer.sv
src/frame_buffer.sv
src/wb_host_regs.sv
src/qspi_burst_writer.sv
src/cam_qspi_top.sv
test/tb_cam_qspi_top.sv

/* src/cam_byte_packer.sv */
module cam_byte_packer import fb_pkg::*; (
	input  logic                  WBs_CLK_i,
	input  logic                  WBs_RST_i,
	input  logic                  cam_pix_en_i,  // One byte per strobe
	input  logic                  cam_href_i,
	input  logic                  cam_vsync_i,
	input  logic [7:0]            cam_dat_i,
	output fb_wr_t                fb_wr_o,
	output logic [BANK_SEL_W-1:0] cam_bank_o     // Bank under the write pointer
);

	logic                byte_vld;   // Byte inside an active line
	logic [1:0]          phase_q;    // Bytes gathered for the current word
	logic [DATA_W-9:0]   shift_q;    // Earlier bytes, oldest on top
	logic                wr_en_q;
	logic [DATA_W-1:0]   wr_data_q;
	logic [FB_AW-1:0]    wr_ptr_q;   // Ring pointer over all banks

	assign byte_vld = cam_pix_en_i & cam_href_i & cam_vsync_i;

	// ----------------------------------------------------------------------
	// Byte phase and ring pointer
	// ----------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			phase_q  <= '0;
			wr_en_q  <= 1'b0;
			wr_ptr_q <= '0;
		end else begin
			wr_en_q <= byte_vld && (phase_q == 2'd3);  // Fourth byte in
			if (byte_vld)
				phase_q <= phase_q + 2'd1;              // Wraps after 4th byte
			if (wr_en_q)
				wr_ptr_q <= wr_ptr_q + FB_AW'(1);       // 2048 word ring
		end
	end

	// Byte packing, first byte ends up in 31:24
	always_ff @(posedge WBs_CLK_i) begin
		if (byte_vld) begin
			shift_q <= {shift_q[DATA_W-17:0], cam_dat_i};
			if (phase_q == 2'd3)
				wr_data_q <= {shift_q, cam_dat_i};
		end
	end

	assign fb_wr_o    = '{en: wr_en_q, addr: wr_ptr_q, data: wr_data_q};
	assign cam_bank_o = wr_ptr_q[FB_AW-1 -: BANK_SEL_W];

	// Four bytes per word, so writes never come back to back
	a_no_back_to_back_wr: assert property (
		@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		fb_wr_o.en |=> !fb_wr_o.en
	) else $error("packer wrote on two consecutive cycles");

endmodule

/* src/cam_qspi_top.sv */
module cam_qspi_top import fb_pkg::*; #(
	parameter logic [QSPI_ADDR_W-1:0] QSPI_BASE_ADDR = 24'h000004,  // SRAM start
	parameter int                     BURST_WORDS    = 128          // 512 bytes
) (
	input  logic              WBs_CLK_i,
	input  logic              WBs_RST_i,
	input  wb_req_t           wb_req_i,
	input  logic              cam_pix_en_i,
	input  logic              cam_href_i,
	input  logic              cam_vsync_i,
	input  logic [7:0]        cam_dat_i,
	output logic [DATA_W-1:0] WBs_DAT_o,
	output logic              WBs_ACK_o,
	output qspi_pins_t        qspi_o
);

	fb_wr_t                fb_wr;          // Packed camera words
	logic [BANK_SEL_W-1:0] cam_bank;
	logic [FB_AW-1:0]      host_rd_addr;   // Port A
	logic [DATA_W-1:0]     host_rd_data;
	logic [FB_AW-1:0]      qspi_rd_addr;   // Port B
	logic [DATA_W-1:0]     qspi_rd_data;
	logic                  qspi_enable;

	// ----------------------------------------------------------------------
	// Camera side
	// ----------------------------------------------------------------------
	cam_byte_packer u_packer (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.cam_pix_en_i (cam_pix_en_i),
		.cam_href_i   (cam_href_i),
		.cam_vsync_i  (cam_vsync_i),
		.cam_dat_i    (cam_dat_i),
		.fb_wr_o      (fb_wr),
		.cam_bank_o   (cam_bank)
	);

	frame_buffer u_fb (
		.WBs_CLK_i   (WBs_CLK_i),
		.fb_wr_i     (fb_wr),
		.rd_a_addr_i (host_rd_addr),
		.rd_b_addr_i (qspi_rd_addr),
		.rd_a_data_o (host_rd_data),
		.rd_b_data_o (qspi_rd_data)
	);

	// ----------------------------------------------------------------------
	// Host and SRAM side
	// ----------------------------------------------------------------------
	wb_host_regs u_regs (
		.WBs_CLK_i     (WBs_CLK_i),
		.WBs_RST_i     (WBs_RST_i),
		.wb_req_i      (wb_req_i),
		.cam_bank_i    (cam_bank),
		.cam_vsync_i   (cam_vsync_i),
		.fb_rd_data_i  (host_rd_data),
		.fb_rd_addr_o  (host_rd_addr),
		.WBs_DAT_o     (WBs_DAT_o),
		.WBs_ACK_o     (WBs_ACK_o),
		.qspi_enable_o (qspi_enable)
	);

	qspi_burst_writer #(
		.QSPI_BASE_ADDR (QSPI_BASE_ADDR),
		.BURST_WORDS    (BURST_WORDS)
	) u_writer (
		.WBs_CLK_i     (WBs_CLK_i),
		.WBs_RST_i     (WBs_RST_i),
		.qspi_enable_i (qspi_enable),
		.cam_bank_i    (cam_bank),
		.rd_data_i     (qspi_rd_data),
		.rd_addr_o     (qspi_rd_addr),
		.qspi_o        (qspi_o)
	);

endmodule

/* src/fb_pkg.sv */
package fb_pkg;

	// ----------------------------------------------------------------------
	// Frame buffer geometry
	// ----------------------------------------------------------------------
	localparam int DATA_W     = 32;                    // Buffer and host word
	localparam int BANK_AW    = 9;                     // 512 words per bank
	localparam int NUM_BANKS  = 4;
	localparam int BANK_SEL_W = 2;                     // Bank number
	localparam int FB_AW      = BANK_SEL_W + BANK_AW;  // Bank bits on top

	// ----------------------------------------------------------------------
	// Quad-SPI SRAM
	// ----------------------------------------------------------------------
	localparam int QSPI_CMD_W  = 8;
	localparam int QSPI_ADDR_W = 24;                   // Byte address, 6 nibbles

	localparam logic [QSPI_CMD_W-1:0] QSPI_CMD_WRITE = 8'h38;  // Quad write

	// Control word bits 1:0
	localparam logic [1:0] MODE_QSPI_WRITE = 2'b10;

	typedef struct packed {
		logic              cyc_fb;    // Frame buffer cycle
		logic              cyc_stat;  // Status/control cycle
		logic              stb;
		logic              we;
		logic [FB_AW-1:0]  adr;       // Word address, bank on top
		logic [DATA_W-1:0] dat;       // Write data
	} wb_req_t;

	typedef struct packed {
		logic              en;        // One cycle per packed word
		logic [FB_AW-1:0]  addr;
		logic [DATA_W-1:0] data;
	} fb_wr_t;

	typedef struct packed {
		logic       ncs;              // Active low chip select
		logic       oe;               // 1 drives the pins
		logic [3:0] dat;
	} qspi_pins_t;

endpackage

/* src/frame_buffer.sv */
module frame_buffer import fb_pkg::*; (
	input  logic              WBs_CLK_i,
	input  fb_wr_t            fb_wr_i,      // Camera side
	input  logic [FB_AW-1:0]  rd_a_addr_i,  // Host side
	input  logic [FB_AW-1:0]  rd_b_addr_i,  // Quad-SPI writer side
	output logic [DATA_W-1:0] rd_a_data_o,
	output logic [DATA_W-1:0] rd_b_data_o
);

	localparam int BANK_WORDS = 1 << BANK_AW;

	logic [DATA_W-1:0]     bank_a_data [NUM_BANKS];  // Per bank read words
	logic [DATA_W-1:0]     bank_b_data [NUM_BANKS];
	logic [BANK_SEL_W-1:0] wr_bank;
	logic [BANK_SEL_W-1:0] rd_a_bank_q;              // Bank of last read
	logic [BANK_SEL_W-1:0] rd_b_bank_q;

	assign wr_bank = fb_wr_i.addr[FB_AW-1 -: BANK_SEL_W];

	// ----------------------------------------------------------------------
	// Banks, one 512x32 block each
	// ----------------------------------------------------------------------
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		logic [DATA_W-1:0] mem [BANK_WORDS];
		logic              we;
		logic [DATA_W-1:0] rd_a_q;
		logic [DATA_W-1:0] rd_b_q;

		assign we = fb_wr_i.en && (wr_bank == BANK_SEL_W'(b));  // Bank decode

		always_ff @(posedge WBs_CLK_i) begin
			if (we)
				mem[fb_wr_i.addr[BANK_AW-1:0]] <= fb_wr_i.data;
			rd_a_q <= mem[rd_a_addr_i[BANK_AW-1:0]];  // Registered reads
			rd_b_q <= mem[rd_b_addr_i[BANK_AW-1:0]];
		end

		assign bank_a_data[b] = rd_a_q;
		assign bank_b_data[b] = rd_b_q;
	end

	// Bank select follows the data by one cycle
	always_ff @(posedge WBs_CLK_i) begin
		rd_a_bank_q <= rd_a_addr_i[FB_AW-1 -: BANK_SEL_W];
		rd_b_bank_q <= rd_b_addr_i[FB_AW-1 -: BANK_SEL_W];
	end

	assign rd_a_data_o = bank_a_data[rd_a_bank_q];
	assign rd_b_data_o = bank_b_data[rd_b_bank_q];

endmodule

/* src/qspi_burst_writer.sv */
module qspi_burst_writer import fb_pkg::*; #(
	parameter logic [QSPI_ADDR_W-1:0] QSPI_BASE_ADDR = 24'h000004,  // First burst
	parameter int                     BURST_WORDS    = 128          // Words per burst
) (
	input  logic                  WBs_CLK_i,
	input  logic                  WBs_RST_i,
	input  logic                  qspi_enable_i,  // Quad write mode
	input  logic [BANK_SEL_W-1:0] cam_bank_i,     // Bank being filled
	input  logic [DATA_W-1:0]     rd_data_i,      // Port B, one cycle late
	output logic [FB_AW-1:0]      rd_addr_o,
	output qspi_pins_t            qspi_o
);

	localparam int                     WORD_W      = $clog2(BURST_WORDS);
	localparam logic [WORD_W-1:0]      LAST_WORD   = WORD_W'(BURST_WORDS - 1);
	localparam logic [QSPI_ADDR_W-1:0] BURST_BYTES = QSPI_ADDR_W'(BURST_WORDS * 4);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CMD,    // 8 bits on dat[0]
		ST_ADDR,   // 6 nibbles
		ST_DATA,   // 8 nibbles per word
		ST_GAP     // ncs high between bursts
	} state_e;

	state_e                 st_q;
	logic [2:0]             cnt_q;        // Bit or nibble in the phase
	logic [WORD_W-1:0]      word_q;       // Word in the burst
	logic [QSPI_ADDR_W-1:0] sram_addr_q;  // Start of the next burst
	logic [FB_AW-1:0]       rd_ptr_q;     // Next frame buffer word to send
	logic [QSPI_CMD_W-1:0]  cmd_sr_q;
	logic [QSPI_ADDR_W-1:0] addr_sr_q;
	logic [DATA_W-1:0]      data_sr_q;
	logic                   start;        // Bank drained side is free
	logic                   go_burst;
	logic                   load_word;    // Take prefetched word
	logic                   send;
	logic [3:0]             nibble;

	// Camera must have left the bank, mode checked at each boundary
	assign start = qspi_enable_i && (rd_ptr_q[FB_AW-1 -: BANK_SEL_W] != cam_bank_i);

	assign go_burst  = start && ((st_q == ST_IDLE) || (st_q == ST_GAP && cnt_q == 3'd1));
	assign load_word = (st_q == ST_ADDR && cnt_q == 3'd5)
	                || (st_q == ST_DATA && cnt_q == 3'd7 && word_q != LAST_WORD);

	// ----------------------------------------------------------------------
	// Phase sequencing
	// ----------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			st_q        <= ST_IDLE;
			cnt_q       <= '0;
			word_q      <= '0;
			sram_addr_q <= QSPI_BASE_ADDR;
			rd_ptr_q    <= '0;
		end else begin
			cnt_q <= cnt_q + 3'd1;                   // Wraps 7 to 0 by itself
			if (load_word)
				rd_ptr_q <= rd_ptr_q + FB_AW'(1);     // Walks all banks in order
			case (st_q)
				ST_IDLE: begin
					cnt_q <= '0;
					if (go_burst)
						st_q <= ST_CMD;
				end
				ST_CMD: begin
					if (cnt_q == 3'd7)
						st_q <= ST_ADDR;
				end
				ST_ADDR: begin
					if (cnt_q == 3'd5) begin
						st_q   <= ST_DATA;
						cnt_q  <= '0;
						word_q <= '0;
					end
				end
				ST_DATA: begin
					if (cnt_q == 3'd7) begin
						word_q <= word_q + WORD_W'(1);
						if (word_q == LAST_WORD) begin
							st_q        <= ST_GAP;
							sram_addr_q <= sram_addr_q + BURST_BYTES;  // 512 bytes on
						end
					end
				end
				ST_GAP: begin
					if (cnt_q == 3'd1) begin
						st_q  <= go_burst ? ST_CMD : ST_IDLE;  // Back to back if free
						cnt_q <= '0;
					end
				end
				default: st_q <= ST_IDLE;
			endcase
		end
	end

	// Shift registers, MSB goes out first
	always_ff @(posedge WBs_CLK_i) begin
		if (go_burst) begin
			cmd_sr_q  <= QSPI_CMD_WRITE;
			addr_sr_q <= sram_addr_q;
		end else begin
			if (st_q == ST_CMD)
				cmd_sr_q <= {cmd_sr_q[QSPI_CMD_W-2:0], 1'b0};
			if (st_q == ST_ADDR)
				addr_sr_q <= {addr_sr_q[QSPI_ADDR_W-5:0], 4'h0};
		end
		if (load_word)
			data_sr_q <= rd_data_i;                  // Fetched during last nibbles
		else if (st_q == ST_DATA)
			data_sr_q <= {data_sr_q[DATA_W-5:0], 4'h0};
	end

	// ----------------------------------------------------------------------
	// Pins
	// ----------------------------------------------------------------------
	assign send = (st_q == ST_CMD) || (st_q == ST_ADDR) || (st_q == ST_DATA);

	always_comb begin
		case (st_q)
			ST_CMD:  nibble = {3'b000, cmd_sr_q[QSPI_CMD_W-1]};  // Serial on dat[0]
			ST_ADDR: nibble = addr_sr_q[QSPI_ADDR_W-1 -: 4];
			ST_DATA: nibble = data_sr_q[DATA_W-1 -: 4];
			default: nibble = 4'h0;
		endcase
	end

	assign rd_addr_o = rd_ptr_q;
	assign qspi_o    = '{ncs: ~send, oe: 1'b1, dat: nibble};  // Write only

	// ncs only rises once the last data nibble of a full burst is out
	a_ncs_send_phase: assert property (
		@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		$rose(qspi_o.ncs) |-> $past(st_q == ST_DATA && word_q == LAST_WORD && cnt_q == 3'd7)
	) else $error("ncs left the send phase early");

endmodule

/* src/wb_host_regs.sv */
module wb_host_regs import fb_pkg::*; (
	input  logic                  WBs_CLK_i,
	input  logic                  WBs_RST_i,
	input  wb_req_t               wb_req_i,
	input  logic [BANK_SEL_W-1:0] cam_bank_i,     // For status bits 1:0
	input  logic                  cam_vsync_i,    // For status bit 8
	input  logic [DATA_W-1:0]     fb_rd_data_i,   // Port A, one cycle late
	output logic [FB_AW-1:0]      fb_rd_addr_o,
	output logic [DATA_W-1:0]     WBs_DAT_o,
	output logic                  WBs_ACK_o,
	output logic                  qspi_enable_o   // Quad write mode selected
);

	logic              req;         // Request seen with ack low
	logic              ctrl_wr;     // Control register write strobe
	logic [1:0]        mode_q;      // Control word bits 1:0
	logic              stat_sel_q;  // Current ack is for a status cycle
	logic [DATA_W-1:0] status;

	// ----------------------------------------------------------------------
	// Decode and acknowledge
	// ----------------------------------------------------------------------
	assign req     = (wb_req_i.cyc_fb | wb_req_i.cyc_stat) & wb_req_i.stb & ~WBs_ACK_o;
	assign ctrl_wr = wb_req_i.cyc_stat & wb_req_i.stb & wb_req_i.we & ~WBs_ACK_o;

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			WBs_ACK_o  <= 1'b0;
			mode_q     <= '0;
			stat_sel_q <= 1'b0;
		end else begin
			WBs_ACK_o <= req;                        // Single cycle ack
			if (ctrl_wr)
				mode_q <= wb_req_i.dat[1:0];          // Lands with the ack edge
			if (req)
				stat_sel_q <= wb_req_i.cyc_stat;
		end
	end

	// ----------------------------------------------------------------------
	// Read data
	// ----------------------------------------------------------------------
	// vsync in bit 8, camera bank in 1:0
	assign status = {{(DATA_W - 9){1'b0}}, cam_vsync_i, 6'b0, cam_bank_i};

	assign fb_rd_addr_o = wb_req_i.adr;              // Word ready with the ack
	assign WBs_DAT_o    = stat_sel_q ? status : fb_rd_data_i;

	assign qspi_enable_o = (mode_q == MODE_QSPI_WRITE);

	// Each request gets one ack, never a stretched one
	a_ack_one_cycle: assert property (
		@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		WBs_ACK_o |=> !WBs_ACK_o
	) else $error("ack high on two consecutive cycles");

endmodule

/* test/tb_cam_qspi_top.sv */
module tb_cam_qspi_top import fb_pkg::*; ();

	localparam int          TIMEOUT_CYCLES  = 20000;          // 640 gapped words plus drains
	localparam int          CAM_WORDS       = 640;
	localparam int          MODE_AT_WORDS   = 300;            // Mode set while still in bank 0
	localparam int          BANK_WORDS      = 512;
	localparam int          BURSTS_PER_BANK = 4;
	localparam int          BURST_SYMS      = 8 + 6 + 128 * 8;  // Cmd, addr, data nibbles
	localparam logic [23:0] SRAM_BASE       = 24'h000004;
	localparam logic [23:0] BURST_STEP      = 24'h000200;     // 512 bytes per burst
	localparam logic [31:0] SEED            = 32'h69d5_1216;

	logic              clk;
	logic              rst;
	wb_req_t           wb_req;
	logic              cam_pix_en;
	logic              cam_href;
	logic              cam_vsync;
	logic [7:0]        cam_dat;
	logic [DATA_W-1:0] wbs_dat;
	logic              wbs_ack;
	qspi_pins_t        qspi;

	logic [DATA_W-1:0] exp_words [NUM_BANKS << BANK_AW];  // Expected frame buffer
	logic [DATA_W-1:0] pack_word;
	int                pack_cnt;
	int                cam_words;                         // Words packed so far
	logic              rd_chk_q;                          // Current access has read data
	logic [DATA_W-1:0] exp_dat_q;
	logic              mode_on_q;
	logic              test_done_q;
	int                cycle_q = 0;
	int                mon_sym_q;                         // Symbols in current frame
	logic [7:0]        mon_cmd_q;
	logic [23:0]       mon_addr_q;
	logic [31:0]       mon_word_q;
	logic [31:0]       word_exp_q;
	logic              word_done_q;
	logic              frame_end_q;
	int                frame_syms_q;
	int                burst_q;                           // Completed bursts
	int                sent_words_q;

	cam_qspi_top dut_i (
		.WBs_CLK_i    (clk),
		.WBs_RST_i    (rst),
		.wb_req_i     (wb_req),
		.cam_pix_en_i (cam_pix_en),
		.cam_href_i   (cam_href),
		.cam_vsync_i  (cam_vsync),
		.cam_dat_i    (cam_dat),
		.WBs_DAT_o    (wbs_dat),
		.WBs_ACK_o    (wbs_ack),
		.qspi_o       (qspi)
	);

	always #4 clk = ~clk;

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic value_error(input string msg);
		abort_run($sformatf("FAILED at time %0t: %s", $time, msg));
	endtask

	always @(posedge clk) begin
		cycle_q <= cycle_q + 1;
		if (cycle_q >= TIMEOUT_CYCLES)
			abort_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
	end

	// ----------------------------------------------------------------------
	// Stimulus and reference model
	// ----------------------------------------------------------------------
	task automatic model_byte(input logic [7:0] b);
		pack_word = {pack_word[23:0], b};                 // First byte ends in 31:24
		pack_cnt  = pack_cnt + 1;
		if (pack_cnt == 4) begin
			exp_words[FB_AW'(cam_words)] = pack_word;
			cam_words = cam_words + 1;
			pack_cnt  = 0;
		end
	endtask

	task automatic cam_byte();
		logic [7:0] b;
		logic       href;
		logic       vsync;
		int         gap;
		b     = 8'($urandom);
		href  = ($urandom_range(0, 7) != 0);              // Some bytes off the line
		vsync = ($urandom_range(0, 9) != 0);
		gap   = $urandom_range(0, 2);
		@(posedge clk);
		cam_pix_en <= 1'b1;
		cam_dat    <= b;
		cam_href   <= href;
		cam_vsync  <= vsync;
		if (href && vsync)
			model_byte(b);
		@(posedge clk);
		cam_pix_en <= 1'b0;
		repeat (gap) @(posedge clk);
	endtask

	task automatic wb_access(input logic stat, input logic write, input int adr,
	                         input logic [DATA_W-1:0] dat, input logic chk,
	                         input logic [DATA_W-1:0] exp_word);
		@(posedge clk);
		wb_req    <= '{cyc_fb: ~stat, cyc_stat: stat, stb: 1'b1, we: write,
		               adr: FB_AW'(adr), dat: dat};
		rd_chk_q  <= chk;
		exp_dat_q <= exp_word;
		do
			@(posedge clk);
		while (!wbs_ack);                                 // Pre-edge ack value
		wb_req   <= '0;                                   // Drop stb on the ack edge
		rd_chk_q <= 1'b0;
	endtask

	task automatic read_status();
		logic [DATA_W-1:0] exp_word;
		exp_word = {23'b0, cam_vsync, 6'b0, 2'(cam_words / BANK_WORDS)};
		wb_access(1'b1, 1'b0, 0, '0, 1'b1, exp_word);
	endtask

	initial begin
		int a;
		void'($urandom(SEED));
		clk         = 1'b0;
		rst         = 1'b1;
		wb_req      = '0;
		cam_pix_en  = 1'b0;
		cam_href    = 1'b0;
		cam_vsync   = 1'b0;
		cam_dat     = 8'h00;
		pack_word   = '0;
		pack_cnt    = 0;
		cam_words   = 0;
		rd_chk_q    = 1'b0;
		exp_dat_q   = '0;
		mode_on_q   = 1'b0;
		test_done_q = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		read_status();                                    // Bank 0, vsync low
		while (cam_words < MODE_AT_WORDS)
			cam_byte();
		wb_access(1'b1, 1'b1, 0, 32'h0000_0002, 1'b0, '0);  // Quad write mode
		mode_on_q <= 1'b1;
		@(posedge clk);
		cam_vsync <= 1'b1;
		@(posedge clk);
		read_status();                                    // vsync high in bit 8
		while (cam_words < CAM_WORDS)
			cam_byte();
		@(posedge clk);
		cam_href <= 1'b0;
		@(posedge clk);
		read_status();                                    // Camera now in bank 1
		for (a = 0; a < CAM_WORDS; a++)
			wb_access(1'b0, 1'b0, a, '0, 1'b1, exp_words[FB_AW'(a)]);
		while (burst_q < BURSTS_PER_BANK)
			@(posedge clk);
		repeat (8) @(posedge clk);                        // Room for a stray burst
		test_done_q <= 1'b1;
		repeat (2) @(posedge clk);
		$display("** PASS **");
		$finish;
	end

	// ----------------------------------------------------------------------
	// Quad-SPI monitor
	// ----------------------------------------------------------------------
	always @(posedge clk) begin
		word_done_q <= 1'b0;
		frame_end_q <= 1'b0;
		if (rst) begin
			mon_sym_q    <= 0;
			burst_q      <= 0;
			sent_words_q <= 0;
		end else begin
			if (frame_end_q)
				burst_q <= burst_q + 1;
			if (!qspi.ncs) begin
				mon_sym_q <= mon_sym_q + 1;
				if (mon_sym_q < 8)
					mon_cmd_q <= {mon_cmd_q[6:0], qspi.dat[0]};  // Serial command
				else if (mon_sym_q < 14)
					mon_addr_q <= {mon_addr_q[19:0], qspi.dat};
				else begin
					mon_word_q <= {mon_word_q[27:0], qspi.dat};
					if (((mon_sym_q - 14) % 8) == 7) begin       // Last nibble of a word
						word_done_q  <= 1'b1;
						word_exp_q   <= exp_words[FB_AW'(sent_words_q)];
						sent_words_q <= sent_words_q + 1;
					end
				end
			end else if (mon_sym_q != 0) begin
				frame_end_q  <= 1'b1;
				frame_syms_q <= mon_sym_q;
				mon_sym_q    <= 0;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------
	a_reset_outputs: assert property (@(posedge clk)
		$fell(rst) |-> !wbs_ack && qspi.ncs && qspi.oe)
		else value_error("outputs not at their reset values");
	a_oe_out: assert property (@(posedge clk) qspi.oe)
		else value_error("quad-SPI oe went low");
	a_ack_follows_stb: assert property (@(posedge clk) disable iff (rst)
		wb_req.stb && !wbs_ack |=> wbs_ack)
		else value_error("no ack one cycle after the request");
	a_no_ack_without_stb: assert property (@(posedge clk) disable iff (rst)
		!wb_req.stb |-> !wbs_ack)
		else value_error("ack without a request");
	a_read_data: assert property (@(posedge clk) disable iff (rst)
		wbs_ack && rd_chk_q |-> wbs_dat == exp_dat_q)
		else value_error($sformatf("read data %h, expected %h", $sampled(wbs_dat),
		                           $sampled(exp_dat_q)));
	a_mode_off_idle: assert property (@(posedge clk) disable iff (rst)
		!mode_on_q |-> qspi.ncs)
		else value_error("ncs low while the mode is off");
	a_burst_bank_free: assert property (@(posedge clk) disable iff (rst)
		$fell(qspi.ncs) |-> cam_words >= BANK_WORDS * (burst_q / BURSTS_PER_BANK + 1))
		else value_error("burst started while the camera was in the bank");
	a_gap_two: assert property (@(posedge clk) disable iff (rst)
		$rose(qspi.ncs) |=> qspi.ncs)
		else value_error("ncs high for less than 2 cycles after a burst");
	a_cmd_serial: assert property (@(posedge clk) disable iff (rst)
		!qspi.ncs && mon_sym_q < 8 |-> qspi.dat[3:1] == 3'b000)
		else value_error("command phase drove dat bits 3:1");
	a_burst_header: assert property (@(posedge clk) disable iff (rst)
		frame_end_q |-> mon_cmd_q == 8'h38 && frame_syms_q == BURST_SYMS
		&& mon_addr_q == SRAM_BASE + 24'(burst_q) * BURST_STEP)
		else value_error($sformatf("burst cmd %h addr %h length %0d", $sampled(mon_cmd_q),
		                           $sampled(mon_addr_q), $sampled(frame_syms_q)));
	a_word_data: assert property (@(posedge clk) disable iff (rst)
		word_done_q |-> mon_word_q == word_exp_q)
		else value_error($sformatf("SRAM word %h, expected %h", $sampled(mon_word_q),
		                           $sampled(word_exp_q)));
	a_drain_count: assert property (@(posedge clk) disable iff (rst)
		test_done_q |-> burst_q == BURSTS_PER_BANK && sent_words_q == BANK_WORDS && qspi.ncs)
		else value_error("bank 0 not drained in exactly four bursts");

endmodule
